// File: mlpInfer.f
+incdir+tests
hw/mlpPkg.sv
hw/featureAssembler.sv
hw/neuronUnit.sv
hw/denseLayer.sv
hw/classSelect.sv
hw/mlpInfer.sv
tests/mlpInferTb.sv

// File: tests/mlpRefModel.svh
`ifndef MLP_REF_MODEL_SVH
`define MLP_REF_MODEL_SVH

// One neuron: wrapping 32-bit sum of products plus bias, then ReLU and bits 28 to 13
function automatic logic [ActWidth-1:0] neuronActivation(
	input logic [NumFeatures-1:0][ActWidth-1:0] x,
	input weightRow w,
	input logic [AccWidth-1:0] bias,
	input int numInputs
);
	longint sum;
	logic [AccWidth-1:0] acc;
	sum = longint'($signed(bias));
	for (int i = 0; i < numInputs; i++)
	begin
		sum += longint'(x[i]) * longint'($signed(w[i]));
	end
	acc = sum[AccWidth-1:0];
	if (acc[AccWidth-1])
	begin
		return '0;
	end
	return acc[FracBits+ActWidth-1:FracBits];
endfunction

function automatic hiddenOutVec hiddenActivations(input hiddenInVec x);
	hiddenOutVec h;
	for (int n = 0; n < NumHidden; n++)
	begin
		h[n] = neuronActivation(x, HiddenWeights[n], HiddenBias[n], NumFeatures);
	end
	return h;
endfunction

function automatic classVec classScores(input hiddenOutVec h);
	logic [NumFeatures-1:0][ActWidth-1:0] wide;
	classVec s;
	wide = '0;
	for (int i = 0; i < NumHidden; i++)
	begin
		wide[i] = h[i];
	end
	for (int c = 0; c < NumClasses; c++)
	begin
		s[c] = neuronActivation(wide, OutWeights[c], OutBias[c], NumHidden);
	end
	return s;
endfunction

// Ties go to the lowest class index
function automatic classResult bestClass(input classVec s);
	classResult best;
	best.classIndex = '0;
	best.score = s[0];
	for (int c = 1; c < NumClasses; c++)
	begin
		if (s[c] > best.score)
		begin
			best.classIndex = ClassIndexWidth'(c);
			best.score = s[c];
		end
	end
	return best;
endfunction

function automatic classResult expectedResult(input hiddenInVec x);
	return bestClass(classScores(hiddenActivations(x)));
endfunction

`endif

// File: tests/mlpInferTb.sv
`timescale 1ns/1ps

module mlpInferTb;

	import mlpPkg::*;

	localparam int ClockPeriod = 40;
	localparam int ResetCycles = 3;
	localparam int ResultLatency = 8;
	localparam int OneHotFrames = 5;
	localparam int RandomFrames = 6;
	localparam int PartialWords = 7;
	localparam int StrayWords = 3;
	// The zero, wrapping and all-ones frames and the frame after the partial one come on top
	localparam int CompleteFrames = OneHotFrames + 2 * RandomFrames + 4;
	localparam int PlannedWords = CompleteFrames * NumFeatures + PartialWords + 2 * StrayWords;
	localparam int TimeoutCycles = PlannedWords * 20 + ResetCycles;

	typedef struct {
		classResult result;
		int due;
	} pendingResult;

	logic clk;
	logic reset;
	logic featureStrobe;
	featureWord feature;
	logic resultStrobe;
	classResult result;

	logic [31:0] lfsrState;
	pendingResult expectQ[$];
	int cycleCount = 0;
	int frameCount = 0;
	int resultCount = 0;
	logic headValid = 1'b0;
	classResult headResult = '0;
	int headDue = 0;

	`include "mlpRefModel.svh"

	mlpInfer dut (
		.clk(clk),
		.reset(reset),
		.featureStrobe(featureStrobe),
		.feature(feature),
		.resultStrobe(resultStrobe),
		.result(result)
	);

	initial
	begin
		clk = 1'b0;
		forever #(ClockPeriod / 2) clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
	end

	// The oldest pending result settles on the falling edge, clear of the sampling edge
	always @(negedge clk)
	begin
		headValid = expectQ.size() > 0;
		if (headValid)
		begin
			headResult = expectQ[0].result;
			headDue = expectQ[0].due;
		end
	end

	always @(posedge clk)
	begin
		if (!reset && resultStrobe)
		begin
			resultCount++;
			if (expectQ.size() > 0)
			begin
				void'(expectQ.pop_front());
			end
		end
	end

	task automatic stopWithFailure(input string message);
		$display("%s", message);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	noUnexpectedResult: assert property (
		@(posedge clk) disable iff (reset) resultStrobe |-> headValid
	) else stopWithFailure($sformatf("resultStrobe pulsed at cycle %0d with no frame pending",
		$sampled(cycleCount)));

	resultOnTime: assert property (
		@(posedge clk) disable iff (reset) resultStrobe && headValid |-> cycleCount == headDue
	) else stopWithFailure($sformatf("resultStrobe came at cycle %0d but was due at cycle %0d",
		$sampled(cycleCount), $sampled(headDue)));

	resultNotMissed: assert property (
		@(posedge clk) disable iff (reset) headValid && cycleCount == headDue |-> resultStrobe
	) else stopWithFailure($sformatf("no resultStrobe at cycle %0d where a result was due",
		$sampled(cycleCount)));

	classIndexMatches: assert property (
		@(posedge clk) disable iff (reset)
		resultStrobe && headValid |-> result.classIndex == headResult.classIndex
	) else stopWithFailure($sformatf("CHECK FAILED result.classIndex: got %h, expected %h",
		$sampled(result.classIndex), $sampled(headResult.classIndex)));

	scoreMatches: assert property (
		@(posedge clk) disable iff (reset)
		resultStrobe && headValid |-> result.score == headResult.score
	) else stopWithFailure($sformatf("CHECK FAILED result.score: got %h, expected %h",
		$sampled(result.score), $sampled(headResult.score)));

	// Taps 32, 22, 2 and 1 give a maximal length sequence
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	function automatic logic [31:0] randomBits(input int width);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < width; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			bits = {bits[30:0], lfsrState[0]};
		end
		return bits;
	endfunction

	function automatic hiddenInVec randomFrame();
		hiddenInVec frame;
		for (int i = 0; i < NumFeatures; i++)
		begin
			frame[i] = ActWidth'(randomBits(ActWidth));
		end
		return frame;
	endfunction

	task automatic driveWord(input logic start, input logic [ActWidth-1:0] word);
		@(posedge clk);
		featureStrobe <= 1'b1;
		feature <= '{frameStart: start, value: word};
	endtask

	task automatic idleCycles(input int count);
		repeat (count)
		begin
			@(posedge clk);
			featureStrobe <= 1'b0;
		end
	endtask

	task automatic sendFrame(input hiddenInVec x, input logic withGaps);
		for (int i = 0; i < NumFeatures; i++)
		begin
			driveWord(i == 0, x[i]);
			if (withGaps && i != NumFeatures - 1)
			begin
				idleCycles(int'(randomBits(2)));
			end
		end
		// The last word is sampled one edge after it is driven
		expectQ.push_back('{result: expectedResult(x), due: cycleCount + ResultLatency + 1});
		frameCount++;
	endtask

	task automatic sendPartialFrame(input int words);
		for (int i = 0; i < words; i++)
		begin
			driveWord(i == 0, ActWidth'(randomBits(ActWidth)));
		end
	endtask

	task automatic sendStrayWords(input int words);
		for (int i = 0; i < words; i++)
		begin
			driveWord(1'b0, ActWidth'(randomBits(ActWidth)));
		end
		idleCycles(1);
	endtask

	initial
	begin
		hiddenInVec frame;
		lfsrState = 32'h22af;
		reset = 1'b1;
		featureStrobe = 1'b0;
		feature = '0;
		repeat (ResetCycles) @(posedge clk);
		reset <= 1'b0;
		idleCycles(4);
		sendStrayWords(StrayWords);
		idleCycles(10);
		sendFrame('0, 1'b0);
		idleCycles(3);
		// Single large features push some hidden sums negative
		for (int i = 0; i < OneHotFrames; i++)
		begin
			frame = '0;
			frame[i * 3 + 2] = '1;
			sendFrame(frame, 1'b0);
			idleCycles(2);
		end
		// Full scale on every positive weight of hidden neuron 1 carries its sum past bit 28
		frame = '0;
		for (int i = 0; i < NumFeatures; i++)
		begin
			if ($signed(HiddenWeights[1][i]) > 0)
			begin
				frame[i] = '1;
			end
		end
		sendFrame(frame, 1'b0);
		idleCycles(2);
		sendFrame('1, 1'b0);
		idleCycles(1);
		for (int i = 0; i < RandomFrames; i++)
		begin
			sendFrame(randomFrame(), 1'b0);
		end
		idleCycles(1);
		for (int i = 0; i < RandomFrames; i++)
		begin
			sendFrame(randomFrame(), 1'b1);
			idleCycles(int'(randomBits(3)));
		end
		sendPartialFrame(PartialWords);
		sendFrame(randomFrame(), 1'b0);
		idleCycles(2);
		sendStrayWords(StrayWords);
		while (expectQ.size() != 0)
		begin
			@(posedge clk);
		end
		idleCycles(2 * ResultLatency);
		if (resultCount == frameCount && frameCount == CompleteFrames && expectQ.size() == 0)
		begin
			$display("RESULT: PASS");
			$finish;
		end
		else
		begin
			stopWithFailure($sformatf("%0d results for %0d complete frames", resultCount,
				frameCount));
		end
	end

	initial
	begin
		#(TimeoutCycles * ClockPeriod);
		stopWithFailure($sformatf("Timeout after %0d cycles with %0d results still pending",
			TimeoutCycles, expectQ.size()));
	end

endmodule

// File: hw/mlpInfer.sv
`timescale 1ns/1ps

module mlpInfer (
	input logic clk,
	input logic reset,
	input logic featureStrobe,
	input mlpPkg::featureWord feature,
	output logic resultStrobe,
	output mlpPkg::classResult result
);

	import mlpPkg::*;

	logic vectorStrobe;
	hiddenInVec features;
	logic hiddenStrobe;
	hiddenOutVec hidden;
	logic scoreStrobe;
	classVec scores;

	featureAssembler assembler (
		.clk(clk),
		.reset(reset),
		.featureStrobe(featureStrobe),
		.feature(feature),
		.vectorStrobe(vectorStrobe),
		.features(features)
	);

	denseLayer #(
		.NumInputs(NumFeatures),
		.NumOutputs(NumHidden),
		.Weights(HiddenWeights),
		.Bias(HiddenBias)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inStrobe(vectorStrobe),
		.inputs(features),
		.outStrobe(hiddenStrobe),
		.outputs(hidden)
	);

	denseLayer #(
		.NumInputs(NumHidden),
		.NumOutputs(NumClasses),
		.Weights(OutWeights),
		.Bias(OutBias)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.inStrobe(hiddenStrobe),
		.inputs(hidden),
		.outStrobe(scoreStrobe),
		.outputs(scores)
	);

	classSelect selector (
		.clk(clk),
		.reset(reset),
		.scoreStrobe(scoreStrobe),
		.scores(scores),
		.resultStrobe(resultStrobe),
		.result(result)
	);

endmodule

// File: hw/classSelect.sv
`timescale 1ns/1ps

module classSelect (
	input logic clk,
	input logic reset,
	input logic scoreStrobe,
	input mlpPkg::classVec scores,
	output logic resultStrobe,
	output mlpPkg::classResult result
);

	import mlpPkg::*;

	logic [ClassIndexWidth-1:0] bestIndex;
	logic [ActWidth-1:0] bestScore;

	// Strict compare keeps the lowest index on a tie
	always_comb
	begin
		bestIndex = '0;
		bestScore = scores[0];
		for (int c = 1; c < NumClasses; c++)
		begin
			if (scores[c] > bestScore)
			begin
				bestIndex = ClassIndexWidth'(c);
				bestScore = scores[c];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			resultStrobe <= 1'b0;
			result <= '0;
		end
		else
		begin
			resultStrobe <= scoreStrobe;
			if (scoreStrobe)
			begin
				result.classIndex <= bestIndex;
				result.score <= bestScore;
			end
		end
	end

	classIndexInRange: assert property (
		@(posedge clk) disable iff (reset)
		resultStrobe |-> result.classIndex < NumClasses
	);

endmodule

// File: hw/denseLayer.sv
`timescale 1ns/1ps

module denseLayer #(
	parameter int NumInputs = 15,
	parameter int NumOutputs = 4,
	parameter mlpPkg::weightRow [NumOutputs-1:0] Weights = '0,
	parameter logic [NumOutputs-1:0][mlpPkg::AccWidth-1:0] Bias = '0
) (
	input logic clk,
	input logic reset,
	input logic inStrobe,
	input logic [NumInputs-1:0][mlpPkg::ActWidth-1:0] inputs,
	output logic outStrobe,
	output logic [NumOutputs-1:0][mlpPkg::ActWidth-1:0] outputs
);

	import mlpPkg::*;

	// One bit per neuron stage, so several vectors may be in flight at once
	logic [NeuronLatency-1:0] validPipe;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[NeuronLatency-2:0], inStrobe};
		end
	end

	assign outStrobe = validPipe[NeuronLatency-1];

	for (genvar n = 0; n < NumOutputs; n++)
	begin : neurons
		neuronUnit #(
			.NumInputs(NumInputs),
			.Weights(Weights[n]),
			.Bias(Bias[n])
		) neuron (
			.clk(clk),
			.reset(reset),
			.inputs(inputs),
			.activation(outputs[n])
		);
	end

endmodule

// File: hw/neuronUnit.sv
`timescale 1ns/1ps

module neuronUnit #(
	parameter int NumInputs = 15,
	parameter mlpPkg::weightRow Weights = '0,
	parameter logic [mlpPkg::AccWidth-1:0] Bias = '0
) (
	input logic clk,
	input logic reset,
	input logic [NumInputs-1:0][mlpPkg::ActWidth-1:0] inputs,
	output logic [mlpPkg::ActWidth-1:0] activation
);

	import mlpPkg::*;

	logic [NumInputs-1:0][ActWidth-1:0] inputReg;
	logic [AccWidth-1:0] sumNext;
	logic [AccWidth-1:0] sumReg;

	// Inputs are unsigned and weights signed, the sum wraps modulo 2**AccWidth
	always_comb
	begin
		sumNext = Bias;
		for (int i = 0; i < NumInputs; i++)
		begin
			sumNext = sumNext
				+ AccWidth'(inputReg[i]) * AccWidth'($signed(Weights[i]));
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputReg <= '0;
		end
		else
		begin
			inputReg <= inputs;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
		end
		else
		begin
			sumReg <= sumNext;
		end
	end

	// ReLU followed by the Q13 slice, high bits above the slice are simply dropped
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			activation <= '0;
		end
		else if (sumReg[AccWidth-1])
		begin
			activation <= '0;
		end
		else
		begin
			activation <= sumReg[FracBits+ActWidth-1:FracBits];
		end
	end

	negativeSumClamped: assert property (
		@(posedge clk) disable iff (reset) sumReg[AccWidth-1] |=> activation == '0
	);

endmodule

// File: hw/featureAssembler.sv
`timescale 1ns/1ps

module featureAssembler (
	input logic clk,
	input logic reset,
	input logic featureStrobe,
	input mlpPkg::featureWord feature,
	output logic vectorStrobe,
	output mlpPkg::hiddenInVec features
);

	import mlpPkg::*;

	// Slot that the next word without frameStart will fill
	logic [SlotWidth-1:0] slot;
	logic frameOpen;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			slot <= '0;
			frameOpen <= 1'b0;
			vectorStrobe <= 1'b0;
			features <= '0;
		end
		else
		begin
			vectorStrobe <= 1'b0;
			if (featureStrobe)
			begin
				if (feature.frameStart)
				begin
					// A new frame always restarts at slot 0 and drops any partial one
					features[0] <= feature.value;
					slot <= SlotWidth'(1);
					frameOpen <= 1'b1;
				end
				else if (frameOpen)
				begin
					features[slot] <= feature.value;
					if (slot == SlotWidth'(NumFeatures - 1))
					begin
						slot <= '0;
						frameOpen <= 1'b0;
						vectorStrobe <= 1'b1;
					end
					else
					begin
						slot <= slot + 1'b1;
					end
				end
			end
		end
	end

	// A full frame needs fifteen words, so two vectors can never be adjacent
	vectorStrobeIsolated: assert property (
		@(posedge clk) disable iff (reset) vectorStrobe |=> !vectorStrobe
	);

endmodule

// File: hw/mlpPkg.sv
package mlpPkg;

	localparam int NumFeatures = 15;
	localparam int NumHidden = 4;
	localparam int NumClasses = 3;
	localparam int ActWidth = 16;
	localparam int WeightWidth = 16;
	localparam int AccWidth = 32;
	localparam int FracBits = 13;
	localparam int NeuronLatency = 3;
	localparam int SlotWidth = $clog2(NumFeatures);
	localparam int ClassIndexWidth = $clog2(NumClasses);

	typedef struct packed {
		logic frameStart;
		logic [ActWidth-1:0] value;
	} featureWord;

	typedef logic [NumFeatures-1:0][ActWidth-1:0] hiddenInVec;
	typedef logic [NumHidden-1:0][ActWidth-1:0] hiddenOutVec;
	typedef logic [NumClasses-1:0][ActWidth-1:0] classVec;

	// Output layer rows only use the low NumHidden entries
	typedef logic [NumFeatures-1:0][WeightWidth-1:0] weightRow;

	typedef struct packed {
		logic [ClassIndexWidth-1:0] classIndex;
		logic [ActWidth-1:0] score;
	} classResult;

	// Each row lists weight 14 first and weight 0 last
	localparam weightRow [NumHidden-1:0] HiddenWeights = '{
		0: '{-16'sd742, 16'sd1893, 16'sd509, -16'sd2214, 16'sd3107,
			16'sd688, -16'sd1540, 16'sd2481, -16'sd96, 16'sd1762,
			-16'sd3318, 16'sd415, 16'sd2950, -16'sd873, 16'sd1204},
		1: '{16'sd1120, 16'sd604, -16'sd1983, 16'sd2719, -16'sd842,
			16'sd1356, 16'sd178, -16'sd3094, 16'sd2245, -16'sd1677,
			16'sd922, 16'sd3871, -16'sd305, 16'sd1418, -16'sd2630},
		2: '{16'sd957, -16'sd3410, 16'sd2186, -16'sd705, 16'sd468,
			-16'sd1129, 16'sd3342, 16'sd1650, -16'sd2877, 16'sd331,
			16'sd2604, -16'sd518, -16'sd1466, 16'sd2088, 16'sd745},
		3: '{-16'sd2201, 16'sd1047, -16'sd618, 16'sd390, 16'sd1575,
			16'sd2934, -16'sd2569, -16'sd1347, 16'sd812, 16'sd3180,
			-16'sd1021, 16'sd2456, 16'sd1733, -16'sd264, -16'sd1892}
	};

	// All hidden biases stay below one Q13 unit, so a zero frame gives zero activations
	localparam logic [NumHidden-1:0][AccWidth-1:0] HiddenBias = '{
		0: 32'sd2310,
		1: -32'sd1544,
		2: 32'sd3875,
		3: -32'sd812
	};

	localparam weightRow [NumClasses-1:0] OutWeights = '{
		0: '{0: 16'sd5120, 1: -16'sd2816, 2: 16'sd3391, 3: 16'sd1742, default: '0},
		1: '{0: -16'sd1963, 1: 16'sd4470, 2: 16'sd2208, 3: -16'sd3125, default: '0},
		2: '{0: 16'sd2780, 1: 16'sd1335, 2: -16'sd4412, 3: 16'sd3906, default: '0}
	};

	localparam logic [NumClasses-1:0][AccWidth-1:0] OutBias = '{
		0: -32'sd1200,
		1: 32'sd2650,
		2: -32'sd3400
	};

endpackage
